//--- hdl/tia_pkg.sv
//////////////////////////////
// TIA element package.
// Sizes, opcodes, instruction and packet types.
//////////////////////////////
`default_nettype none

package tia_pkg;

    localparam int word_width = 32;
    localparam int tag_width = 2;
    localparam int imm_width = 16;
    localparam int num_in_channels = 2;
    localparam int num_out_channels = 2;
    localparam int chan_index_width = 1;
    localparam int num_registers = 4;
    localparam int reg_index_width = 2;
    localparam int num_predicates = 4;
    localparam int num_instructions = 8;
    localparam int instr_index_width = 3;
    localparam int buffer_depth = 2;
    localparam int buffer_ptr_width = 1;
    localparam int buffer_count_width = 2;

    typedef logic [word_width-1:0] word_t;
    typedef logic [tag_width-1:0] tag_t;

    typedef struct packed {
        tag_t tag;
        word_t data;
    } packet_t;

    typedef enum logic [3:0] {
        op_nop = 4'd0,
        op_mov = 4'd1,
        op_add = 4'd2,
        op_sub = 4'd3,
        op_and = 4'd4,
        op_or = 4'd5,
        op_xor = 4'd6,
        op_eq = 4'd7,
        op_halt = 4'd8
    } op_t;

    typedef enum logic [1:0] {
        src_imm = 2'd0,
        src_reg = 2'd1,
        src_in = 2'd2
    } src_t;

    typedef enum logic [1:0] {
        dst_none = 2'd0,
        dst_reg = 2'd1,
        dst_out = 2'd2,
        dst_pred = 2'd3
    } dst_t;

    typedef struct packed {
        logic valid;
        logic [num_predicates-1:0] pred_on;
        logic [num_predicates-1:0] pred_off;
        logic [num_in_channels-1:0] in_mask;
        tag_t [num_in_channels-1:0] in_tag;
    } trigger_t;

    typedef struct packed {
        trigger_t trig;
        op_t op;
        src_t src0_kind;
        logic [reg_index_width-1:0] src0_index;
        src_t src1_kind;
        logic [reg_index_width-1:0] src1_index;
        logic [imm_width-1:0] imm;
        dst_t dst_kind;
        logic [reg_index_width-1:0] dst_index;
        tag_t out_tag;
        logic [num_in_channels-1:0] deq_mask;
        logic [num_predicates-1:0] pred_mask;
        logic [num_predicates-1:0] pred_value;
    } instr_t;

    // Output channels an instruction enqueues to.
    function automatic logic [num_out_channels-1:0] out_write_mask(instr_t instr);
        logic [num_out_channels-1:0] mask;
        mask = '0;
        if (instr.dst_kind == dst_out) begin
            mask[instr.dst_index[chan_index_width-1:0]] = 1'b1;
        end
        return mask;
    endfunction

    function automatic logic pred_writer(instr_t instr);
        return (instr.dst_kind == dst_pred) || (instr.pred_mask != '0);
    endfunction

endpackage

`default_nettype wire

//--- hdl/tia_if.sv
//////////////////////////////
// Channel and stage interfaces.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface chan_if;
    tia_pkg::packet_t head;
    logic not_empty;
    logic not_full;
    logic push;
    tia_pkg::packet_t push_packet;
    logic pop;

    modport buffer (
        output head, not_empty, not_full,
        input push, push_packet, pop
    );

    modport core (
        input head, not_empty, not_full,
        output push, push_packet, pop
    );
endinterface

// Downstream D and X state seen by the trigger stage.
interface stage_if;
    logic [tia_pkg::num_in_channels-1:0] d_deq_mask;
    logic [tia_pkg::num_out_channels-1:0] d_out_mask;
    logic [tia_pkg::num_out_channels-1:0] x_out_mask;
    logic d_pred_writer;
    logic x_pred_writer;
    logic x_pred_we;
    logic [tia_pkg::num_predicates-1:0] x_pred_mask;
    logic [tia_pkg::num_predicates-1:0] x_pred_value;

    modport datapath (
        output d_deq_mask, d_out_mask, x_out_mask, d_pred_writer, x_pred_writer,
        output x_pred_we, x_pred_mask, x_pred_value
    );

    modport trigger (
        input d_deq_mask, d_out_mask, x_out_mask, d_pred_writer, x_pred_writer,
        input x_pred_we, x_pred_mask, x_pred_value
    );
endinterface

`default_nettype wire

//--- hdl/channel_buffer.sv
//////////////////////////////
// Channel buffer.
// Two-entry tagged packet FIFO.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module channel_buffer (
    input logic clock,
    input logic rst,
    input logic link_valid,
    output logic link_ready,
    input tia_pkg::packet_t link_packet,
    chan_if.buffer port
);

    tia_pkg::packet_t mem [tia_pkg::buffer_depth];
    logic [tia_pkg::buffer_ptr_width-1:0] rd_ptr;
    logic [tia_pkg::buffer_ptr_width-1:0] wr_ptr;
    logic [tia_pkg::buffer_count_width-1:0] count;
    logic enq;
    logic deq;

    assign link_ready = (count != tia_pkg::buffer_count_width'(tia_pkg::buffer_depth));
    assign enq = link_valid && link_ready;
    assign deq = port.pop && port.not_empty;

    assign port.head = mem[rd_ptr];
    assign port.not_empty = (count != '0);
    assign port.not_full = link_ready;

    always_ff @(posedge clock) begin
        if (enq) begin
            mem[wr_ptr] <= link_packet;
        end
    end

    // Pointers wrap naturally at depth two.
    always_ff @(posedge clock) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (enq) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + tia_pkg::buffer_count_width'(enq)
                - tia_pkg::buffer_count_width'(deq);
        end
    end

endmodule

`default_nettype wire

//--- hdl/trigger_unit.sv
//////////////////////////////
// Trigger stage.
// Instruction table, predicates, trigger
// resolution and the T|D register.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module trigger_unit (
    input logic clock,
    input logic rst,
    input logic execute,
    input logic halted,
    input logic prog_valid,
    input logic [tia_pkg::instr_index_width-1:0] prog_index,
    input tia_pkg::instr_t prog_instr,
    chan_if.core in_ch [tia_pkg::num_in_channels],
    chan_if.core out_ch [tia_pkg::num_out_channels],
    stage_if.trigger stage,
    output tia_pkg::instr_t d_instr,
    output logic d_valid
);

    tia_pkg::instr_t table_q [tia_pkg::num_instructions];
    logic [tia_pkg::num_instructions-1:0] loaded;
    logic [tia_pkg::num_predicates-1:0] preds;
    logic [tia_pkg::num_in_channels-1:0] in_avail;
    tia_pkg::tag_t in_tag [tia_pkg::num_in_channels];
    logic [tia_pkg::num_out_channels-1:0] out_room;
    logic [tia_pkg::num_instructions-1:0] ready;
    logic [tia_pkg::instr_index_width-1:0] sel;
    logic hazard;
    logic fire;

    // Program load, only while stopped.
    always_ff @(posedge clock) begin
        if (prog_valid && !execute) begin
            table_q[prog_index] <= prog_instr;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            loaded <= '0;
        end else if (prog_valid && !execute) begin
            loaded[prog_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            preds <= '0;
        end else if (stage.x_pred_we) begin
            preds <= (preds & ~stage.x_pred_mask)
                | (stage.x_pred_value & stage.x_pred_mask);
        end
    end

    // Pessimistic status. Pending dequeues look empty, pending enqueues full.
    for (genvar c = 0; c < tia_pkg::num_in_channels; c++) begin : g_in
        assign in_avail[c] = in_ch[c].not_empty && !stage.d_deq_mask[c];
        assign in_tag[c] = in_ch[c].head.tag;
    end

    for (genvar c = 0; c < tia_pkg::num_out_channels; c++) begin : g_out
        assign out_room[c] = out_ch[c].not_full && !stage.d_out_mask[c]
            && !stage.x_out_mask[c];
    end

    always_comb begin
        tia_pkg::trigger_t trig;
        logic [tia_pkg::num_in_channels-1:0] need;
        for (int i = 0; i < tia_pkg::num_instructions; i++) begin
            trig = table_q[i].trig;
            need = trig.in_mask | table_q[i].deq_mask;
            ready[i] = loaded[i] && trig.valid
                && ((preds & trig.pred_on) == trig.pred_on)
                && ((preds & trig.pred_off) == '0)
                && ((need & ~in_avail) == '0)
                && ((tia_pkg::out_write_mask(table_q[i]) & ~out_room) == '0);
            for (int c = 0; c < tia_pkg::num_in_channels; c++) begin
                if (trig.in_mask[c] && (in_tag[c] != trig.in_tag[c])) begin
                    ready[i] = 1'b0;
                end
            end
        end
    end

    // Lowest index wins.
    always_comb begin
        sel = '0;
        for (int i = tia_pkg::num_instructions - 1; i >= 0; i--) begin
            if (ready[i]) begin
                sel = i[tia_pkg::instr_index_width-1:0];
            end
        end
    end

    assign hazard = stage.d_pred_writer || stage.x_pred_writer;
    assign fire = execute && !halted && !hazard && (ready != '0);

    always_ff @(posedge clock) begin
        if (rst) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= fire;
        end
    end

    always_ff @(posedge clock) begin
        d_instr <= table_q[sel];
    end

endmodule

`default_nettype wire

//--- hdl/datapath.sv
//////////////////////////////
// Datapath for the D and X stages.
// Operand fetch, D|X register, ALU
// and result routing.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module datapath (
    input logic clock,
    input logic rst,
    input tia_pkg::instr_t d_instr,
    input logic d_valid,
    chan_if.core in_ch [tia_pkg::num_in_channels],
    chan_if.core out_ch [tia_pkg::num_out_channels],
    stage_if.datapath stage,
    output logic halt_retired
);

    tia_pkg::word_t regs [tia_pkg::num_registers];
    tia_pkg::word_t in_data [tia_pkg::num_in_channels];
    tia_pkg::word_t d_op0;
    tia_pkg::word_t d_op1;
    tia_pkg::instr_t x_instr;
    logic x_valid;
    tia_pkg::word_t x_op0;
    tia_pkg::word_t x_op1;
    tia_pkg::word_t x_result;
    logic x_reg_write;
    logic [tia_pkg::num_out_channels-1:0] x_out_mask;
    logic [tia_pkg::num_predicates-1:0] dst_bit;

    assign x_reg_write = x_valid && (x_instr.dst_kind == tia_pkg::dst_reg);
    assign x_out_mask = x_valid ? tia_pkg::out_write_mask(x_instr) : '0;

    // Input heads in, dequeues out.
    for (genvar c = 0; c < tia_pkg::num_in_channels; c++) begin : g_in
        assign in_data[c] = in_ch[c].head.data;
        assign in_ch[c].pop = d_valid && d_instr.deq_mask[c];
    end

    for (genvar c = 0; c < tia_pkg::num_out_channels; c++) begin : g_out
        assign out_ch[c].push = x_out_mask[c];
        assign out_ch[c].push_packet = '{tag: x_instr.out_tag, data: x_result};
    end

    // Operand source with X forwarding.
    function automatic tia_pkg::word_t fetch(tia_pkg::src_t kind,
                                             logic [tia_pkg::reg_index_width-1:0] index);
        tia_pkg::word_t value;
        case (kind)
            tia_pkg::src_reg: begin
                if (x_reg_write && (x_instr.dst_index == index)) begin
                    value = x_result;
                end else begin
                    value = regs[index];
                end
            end
            tia_pkg::src_in: value = in_data[index[tia_pkg::chan_index_width-1:0]];
            default: value = tia_pkg::word_t'(d_instr.imm);
        endcase
        return value;
    endfunction

    always_comb begin
        d_op0 = fetch(d_instr.src0_kind, d_instr.src0_index);
        d_op1 = fetch(d_instr.src1_kind, d_instr.src1_index);
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            x_valid <= 1'b0;
        end else begin
            x_valid <= d_valid;
        end
    end

    always_ff @(posedge clock) begin
        x_instr <= d_instr;
        x_op0 <= d_op0;
        x_op1 <= d_op1;
    end

    always_comb begin
        case (x_instr.op)
            tia_pkg::op_mov: x_result = x_op0;
            tia_pkg::op_add: x_result = x_op0 + x_op1;
            tia_pkg::op_sub: x_result = x_op0 - x_op1;
            tia_pkg::op_and: x_result = x_op0 & x_op1;
            tia_pkg::op_or: x_result = x_op0 | x_op1;
            tia_pkg::op_xor: x_result = x_op0 ^ x_op1;
            tia_pkg::op_eq: x_result = tia_pkg::word_t'(x_op0 == x_op1);
            default: x_result = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (x_reg_write) begin
            regs[x_instr.dst_index] <= x_result;
        end
    end

    // A predicate destination takes bit 0 of the result.
    always_comb begin
        dst_bit = '0;
        if (x_instr.dst_kind == tia_pkg::dst_pred) begin
            dst_bit[x_instr.dst_index] = 1'b1;
        end
    end

    assign stage.x_pred_we = x_valid && tia_pkg::pred_writer(x_instr);
    assign stage.x_pred_writer = stage.x_pred_we;
    assign stage.x_pred_mask = x_instr.pred_mask | dst_bit;
    assign stage.x_pred_value = (x_instr.pred_value & ~dst_bit)
        | ({tia_pkg::num_predicates{x_result[0]}} & dst_bit);
    assign stage.d_pred_writer = d_valid && tia_pkg::pred_writer(d_instr);
    assign stage.d_deq_mask = d_valid ? d_instr.deq_mask : '0;
    assign stage.d_out_mask = d_valid ? tia_pkg::out_write_mask(d_instr) : '0;
    assign stage.x_out_mask = x_out_mask;

    assign halt_retired = x_valid && (x_instr.op == tia_pkg::op_halt);

endmodule

`default_nettype wire

//--- hdl/tia_core.sv
//////////////////////////////
// TIA processing element top.
// Channel buffers, trigger stage, datapath.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tia_core (
    input logic clock,
    input logic rst,
    input logic execute,
    input logic prog_valid,
    output logic prog_ready,
    input logic [tia_pkg::instr_index_width-1:0] prog_index,
    input tia_pkg::instr_t prog_instr,
    input logic [tia_pkg::num_in_channels-1:0] in_valid,
    output logic [tia_pkg::num_in_channels-1:0] in_ready,
    input tia_pkg::tag_t in_tag [tia_pkg::num_in_channels],
    input tia_pkg::word_t in_data [tia_pkg::num_in_channels],
    output logic [tia_pkg::num_out_channels-1:0] out_valid,
    input logic [tia_pkg::num_out_channels-1:0] out_ready,
    output tia_pkg::tag_t out_tag [tia_pkg::num_out_channels],
    output tia_pkg::word_t out_data [tia_pkg::num_out_channels],
    output logic halted,
    output logic channels_quiescent
);

    chan_if in_ch [tia_pkg::num_in_channels] ();
    chan_if out_ch [tia_pkg::num_out_channels] ();
    stage_if stage ();

    tia_pkg::instr_t d_instr;
    logic d_valid;
    logic halt_retired;
    logic [tia_pkg::num_in_channels-1:0] in_empty;
    logic [tia_pkg::num_out_channels-1:0] out_empty;

    assign prog_ready = !execute;

    for (genvar i = 0; i < tia_pkg::num_in_channels; i++) begin : g_in
        tia_pkg::packet_t in_packet;
        assign in_packet = '{tag: in_tag[i], data: in_data[i]};
        assign in_ch[i].push = in_valid[i] && in_ready[i];
        assign in_ch[i].push_packet = in_packet;
        assign in_empty[i] = !in_ch[i].not_empty;
        channel_buffer u_buf (
            .clock(clock),
            .rst(rst),
            .link_valid(in_ch[i].push),
            .link_ready(in_ready[i]),
            .link_packet(in_ch[i].push_packet),
            .port(in_ch[i])
        );
    end

    // Output buffers drain to the link.
    for (genvar j = 0; j < tia_pkg::num_out_channels; j++) begin : g_out
        assign out_ch[j].pop = out_ch[j].not_empty && out_ready[j];
        assign out_valid[j] = out_ch[j].not_empty;
        assign out_tag[j] = out_ch[j].head.tag;
        assign out_data[j] = out_ch[j].head.data;
        assign out_empty[j] = !out_ch[j].not_empty;
        channel_buffer u_buf (
            .clock(clock),
            .rst(rst),
            .link_valid(out_ch[j].push),
            .link_ready(),
            .link_packet(out_ch[j].push_packet),
            .port(out_ch[j])
        );
    end

    trigger_unit u_trigger (
        .clock(clock),
        .rst(rst),
        .execute(execute),
        .halted(halted),
        .prog_valid(prog_valid),
        .prog_index(prog_index),
        .prog_instr(prog_instr),
        .in_ch(in_ch),
        .out_ch(out_ch),
        .stage(stage),
        .d_instr(d_instr),
        .d_valid(d_valid)
    );

    datapath u_datapath (
        .clock(clock),
        .rst(rst),
        .d_instr(d_instr),
        .d_valid(d_valid),
        .in_ch(in_ch),
        .out_ch(out_ch),
        .stage(stage),
        .halt_retired(halt_retired)
    );

    // Sticky until reset.
    always_ff @(posedge clock) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (halt_retired) begin
            halted <= 1'b1;
        end
    end

    assign channels_quiescent = (&in_empty) && (&out_empty);

endmodule

`default_nettype wire

//--- bench/tia_core_assert.sv
//////////////////////////////
// Channel and halt checker.
// Bound into the TIA element top.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tia_core_assert (
    input logic clock,
    input logic rst,
    input logic [tia_pkg::num_in_channels-1:0] pop,
    input logic [tia_pkg::num_in_channels-1:0] not_empty,
    input logic [tia_pkg::num_out_channels-1:0] push,
    input logic [tia_pkg::num_out_channels-1:0] not_full,
    input logic d_valid,
    input logic halted
);

    int violations = 0;

    for (genvar c = 0; c < tia_pkg::num_in_channels; c++) begin : g_in
        a_pop_not_empty: assert property (@(posedge clock) disable iff (rst)
            pop[c] |-> not_empty[c])
            else begin
                violations++;
                $error("pop on empty input channel %0d", c);
            end
    end

    for (genvar c = 0; c < tia_pkg::num_out_channels; c++) begin : g_out
        a_push_not_full: assert property (@(posedge clock) disable iff (rst)
            push[c] |-> not_full[c])
            else begin
                violations++;
                $error("push on full output channel %0d", c);
            end
    end

    // Halted stays up and the trigger stage issues nothing more.
    a_halted_stops: assert property (@(posedge clock) disable iff (rst)
        halted |=> (halted && !d_valid))
        else begin
            violations++;
            $error("halted fell without reset or an instruction issued after halt");
        end

endmodule

`default_nettype wire

//--- bench/tia_core_tb.sv
//////////////////////////////
// TIA element testbench.
// Program load, table-driven packets, checks.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tia_core_tb;

    typedef struct {
        logic [tia_pkg::num_in_channels-1:0] in_mask;
        tia_pkg::tag_t tag;
        tia_pkg::word_t data0;
        tia_pkg::word_t data1;
        logic has_out;
        int out_chan;
        tia_pkg::tag_t out_tag;
        tia_pkg::word_t out_value;
    } row_t;

    localparam int wait_limit = 200;
    localparam int num_rows = 8;

    logic clock;
    logic rst;
    logic execute;
    logic prog_valid;
    logic prog_ready;
    logic [tia_pkg::instr_index_width-1:0] prog_index;
    tia_pkg::instr_t prog_instr;
    logic [tia_pkg::num_in_channels-1:0] in_valid;
    logic [tia_pkg::num_in_channels-1:0] in_ready;
    tia_pkg::tag_t in_tag [tia_pkg::num_in_channels];
    tia_pkg::word_t in_data [tia_pkg::num_in_channels];
    logic [tia_pkg::num_out_channels-1:0] out_valid;
    logic [tia_pkg::num_out_channels-1:0] out_ready;
    tia_pkg::tag_t out_tag [tia_pkg::num_out_channels];
    tia_pkg::word_t out_data [tia_pkg::num_out_channels];
    logic halted;
    logic channels_quiescent;

    tia_pkg::instr_t program_rom [tia_pkg::num_instructions];
    row_t rows [num_rows];
    integer seed = 25055;

    tia_core UUT (
        .clock(clock),
        .rst(rst),
        .execute(execute),
        .prog_valid(prog_valid),
        .prog_ready(prog_ready),
        .prog_index(prog_index),
        .prog_instr(prog_instr),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .in_tag(in_tag),
        .in_data(in_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .out_tag(out_tag),
        .out_data(out_data),
        .halted(halted),
        .channels_quiescent(channels_quiescent)
    );

    bind tia_core tia_core_assert u_assert (
        .clock(clock),
        .rst(rst),
        .pop({in_ch[1].pop, in_ch[0].pop}),
        .not_empty({in_ch[1].not_empty, in_ch[0].not_empty}),
        .push({out_ch[1].push, out_ch[0].push}),
        .not_full({out_ch[1].not_full, out_ch[0].not_full}),
        .d_valid(d_valid),
        .halted(halted)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Random back-pressure on both outputs.
    initial begin
        forever begin
            @(posedge clock);
            out_ready <= 2'($random(seed));
        end
    end

    task automatic report_failure();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic abort_run(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        report_failure();
    endtask

    task automatic check_word(input string name, input tia_pkg::word_t actual,
                              input tia_pkg::word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_tag(input string name, input tia_pkg::tag_t actual,
                             input tia_pkg::tag_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
            report_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, actual, expected);
            report_failure();
        end
    endtask

    always @(negedge clock) begin
        if (UUT.u_assert.violations != 0) begin
            abort_run("a bound assertion on the channel or halt rules failed");
        end
    end

    task automatic fill_program();
        // Trigger {valid, pred_on, pred_off, in_mask, {tag1, tag0}}, op, src0, src1,
        // immediate, destination, out_tag, deq_mask, pred_mask, pred_value.
        program_rom[0] = '{'{1'b1, 4'b0000, 4'b0000, 2'b11, {2'd0, 2'd0}},
            tia_pkg::op_add, tia_pkg::src_in, 2'd0, tia_pkg::src_in, 2'd1, 16'h0000,
            tia_pkg::dst_out, 2'd0, 2'd1, 2'b11, 4'b0000, 4'b0000};
        program_rom[1] = '{'{1'b1, 4'b0000, 4'b0000, 2'b01, {2'd0, 2'd1}},
            tia_pkg::op_xor, tia_pkg::src_in, 2'd0, tia_pkg::src_imm, 2'd0, 16'hA5C3,
            tia_pkg::dst_out, 2'd1, 2'd2, 2'b01, 4'b0000, 4'b0000};
        program_rom[2] = '{'{1'b1, 4'b0000, 4'b0001, 2'b11, {2'd2, 2'd2}},
            tia_pkg::op_mov, tia_pkg::src_in, 2'd0, tia_pkg::src_imm, 2'd0, 16'h0000,
            tia_pkg::dst_reg, 2'd1, 2'd0, 2'b01, 4'b0000, 4'b0000};
        // Reads register 1 while the move is still in X.
        program_rom[3] = '{'{1'b1, 4'b0000, 4'b0001, 2'b10, {2'd2, 2'd0}},
            tia_pkg::op_eq, tia_pkg::src_reg, 2'd1, tia_pkg::src_in, 2'd1, 16'h0000,
            tia_pkg::dst_pred, 2'd0, 2'd0, 2'b10, 4'b0000, 4'b0000};
        program_rom[4] = '{'{1'b1, 4'b0001, 4'b0000, 2'b00, {2'd0, 2'd0}},
            tia_pkg::op_mov, tia_pkg::src_reg, 2'd1, tia_pkg::src_imm, 2'd0, 16'h0000,
            tia_pkg::dst_out, 2'd0, 2'd3, 2'b00, 4'b0001, 4'b0000};
        program_rom[5] = '{'{1'b1, 4'b0000, 4'b0000, 2'b01, {2'd0, 2'd3}},
            tia_pkg::op_halt, tia_pkg::src_imm, 2'd0, tia_pkg::src_imm, 2'd0, 16'h0000,
            tia_pkg::dst_none, 2'd0, 2'd0, 2'b01, 4'b0000, 4'b0000};
        program_rom[6] = '{'{1'b1, 4'b0000, 4'b0000, 2'b10, {2'd1, 2'd0}},
            tia_pkg::op_sub, tia_pkg::src_in, 2'd1, tia_pkg::src_imm, 2'd0, 16'h0100,
            tia_pkg::dst_out, 2'd1, 2'd0, 2'b10, 4'b0000, 4'b0000};
        program_rom[7] = '{'{1'b1, 4'b0000, 4'b0000, 2'b10, {2'd3, 2'd0}},
            tia_pkg::op_or, tia_pkg::src_in, 2'd1, tia_pkg::src_imm, 2'd0, 16'h0F0F,
            tia_pkg::dst_out, 2'd0, 2'd2, 2'b10, 4'b0000, 4'b0000};
    endtask

    // In mask, tag, data0, data1, has_out, out channel, out tag, out value.
    task automatic fill_rows();
        rows[0] = '{2'b11, 2'd0, 32'h1234_5678, 32'h0111_1111, 1'b1, 0, 2'd1, 32'h1345_6789};
        rows[1] = '{2'b01, 2'd1, 32'hDEAD_BEEF, 32'h0000_0000, 1'b1, 1, 2'd2, 32'hDEAD_1B2C};
        rows[2] = '{2'b11, 2'd2, 32'hCAFE_0042, 32'hCAFE_0042, 1'b1, 0, 2'd3, 32'hCAFE_0042};
        rows[3] = '{2'b10, 2'd1, 32'h0000_0000, 32'h0000_0500, 1'b1, 1, 2'd0, 32'h0000_0400};
        rows[4] = '{2'b10, 2'd3, 32'h0000_0000, 32'h1200_0000, 1'b1, 0, 2'd2, 32'h1200_0F0F};
        rows[5] = '{2'b11, 2'd0, 32'hFFFF_FFF0, 32'h0000_0020, 1'b1, 0, 2'd1, 32'h0000_0010};
        rows[6] = '{2'b11, 2'd2, 32'h0BAD_F00D, 32'h0BAD_F00D, 1'b1, 0, 2'd3, 32'h0BAD_F00D};
        rows[7] = '{2'b01, 2'd3, 32'h0000_0000, 32'h0000_0000, 1'b0, 0, 2'd0, 32'h0000_0000};
    endtask

    task automatic load_program();
        int cycles;
        for (int i = 0; i < tia_pkg::num_instructions; i++) begin
            @(posedge clock);
            prog_valid <= 1'b1;
            prog_index <= tia_pkg::instr_index_width'(i);
            prog_instr <= program_rom[i];
            cycles = 0;
            do begin
                @(negedge clock);
                cycles++;
                if (cycles > wait_limit) begin
                    abort_run("timeout waiting for prog_ready during program load");
                end
            end while (!prog_ready);
        end
        @(posedge clock);
        prog_valid <= 1'b0;
    endtask

    task automatic receive_output(input int chan, input tia_pkg::tag_t tag,
                                  input tia_pkg::word_t value);
        int cycles;
        cycles = 0;
        forever begin
            @(negedge clock);
            if (out_valid[1 - chan]) begin
                abort_run($sformatf("unexpected packet on output channel %0d", 1 - chan));
            end
            if (out_valid[chan] && out_ready[chan]) begin
                break;
            end
            cycles++;
            if (cycles > wait_limit) begin
                abort_run($sformatf("timeout waiting for output channel %0d", chan));
            end
        end
        check_tag($sformatf("out_tag[%0d]", chan), out_tag[chan], tag);
        check_word($sformatf("out_data[%0d]", chan), out_data[chan], value);
    endtask

    task automatic wait_halt_and_drain();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("timeout waiting for halted to rise");
            end
        end while (!halted);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("timeout waiting for the channel buffers to drain");
            end
        end while (!channels_quiescent);
        check_bit("halted", halted, 1'b1);
    endtask

    task automatic apply_row(input row_t r);
        int cycles;
        @(posedge clock);
        in_valid <= r.in_mask;
        in_tag[0] <= r.tag;
        in_tag[1] <= r.tag;
        in_data[0] <= r.data0;
        in_data[1] <= r.data1;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
            if (cycles > wait_limit) begin
                abort_run("timeout waiting for in_ready on the input channels");
            end
        end while ((in_ready & r.in_mask) != r.in_mask);
        @(posedge clock);
        in_valid <= '0;
        if (r.has_out) begin
            receive_output(r.out_chan, r.out_tag, r.out_value);
            check_bit("halted", halted, 1'b0);
        end else begin
            wait_halt_and_drain();
        end
    endtask

    initial begin
        rst = 1'b1;
        execute = 1'b0;
        prog_valid = 1'b0;
        prog_index = '0;
        prog_instr = '0;
        in_valid = '0;
        out_ready = '0;
        for (int c = 0; c < tia_pkg::num_in_channels; c++) begin
            in_tag[c] = '0;
            in_data[c] = '0;
        end
        fill_program();
        fill_rows();
        repeat (16) @(posedge clock);
        rst <= 1'b0;
        @(negedge clock);
        check_bit("halted", halted, 1'b0);
        check_bit("out_valid[0]", out_valid[0], 1'b0);
        check_bit("out_valid[1]", out_valid[1], 1'b0);
        check_bit("channels_quiescent", channels_quiescent, 1'b1);
        check_bit("prog_ready", prog_ready, 1'b1);
        load_program();
        @(posedge clock);
        execute <= 1'b1;
        @(negedge clock);
        check_bit("prog_ready", prog_ready, 1'b0);
        for (int i = 0; i < num_rows; i++) begin
            apply_row(rows[i]);
        end
        if (UUT.u_assert.violations == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_failure();
        end
    end

endmodule

`default_nettype wire

//--- list.f
hdl/tia_pkg.sv
hdl/tia_if.sv
hdl/channel_buffer.sv
hdl/trigger_unit.sv
hdl/datapath.sv
hdl/tia_core.sv
bench/tia_core_assert.sv
bench/tia_core_tb.sv

//--- Bender.yml
package:
  name: tia_core

sources:
  - files:
      - hdl/tia_pkg.sv
      - hdl/tia_if.sv
      - hdl/channel_buffer.sv
      - hdl/trigger_unit.sv
      - hdl/datapath.sv
      - hdl/tia_core.sv
  - target: test
    files:
      - bench/tia_core_assert.sv
      - bench/tia_core_tb.sv
